/* source/convImgPkg.sv */
package convImgPkg;

    // address width of both row buffers
    localparam int ADDR_W = 10;

    // cycles from a pixel read address to its result at the convolver output:
    // buffer read 1, window shift 1, multiply 1, adder tree 2
    localparam int PIPE_LATENCY = 5;

    typedef logic [7:0] pixel_t;

    typedef logic signed [7:0] coef_t;

    typedef logic signed [19:0] result_t;

    // result j = tap0*x[j] + tap1*x[j+1] + tap2*x[j+2]
    typedef struct packed {
        coef_t tap0;
        coef_t tap1;
        coef_t tap2;
    } kernel_t;

    localparam kernel_t DEFAULT_KERNEL = '{
        tap0: 8'sd1,
        tap1: -8'sd2,
        tap2: 8'sd3
    };

endpackage

/* source/convCtrlPkg.sv */
package convCtrlPkg;

    // XFER covers both pixel load and result readout,
    // the end-of-process flag tells them apart
    typedef enum logic [1:0] {
        IDLE,
        XFER,
        PROCESS,
        DONE
    } phase_t;

    // buffer read strobe
    typedef struct packed {
        logic                          rdEn;
        logic [convImgPkg::ADDR_W-1:0] rdAddr;
    } rdCmd_t;

    // buffer write strobe, data travels beside it
    typedef struct packed {
        logic                          wrEn;
        logic [convImgPkg::ADDR_W-1:0] wrAddr;
    } wrCmd_t;

endpackage

/* source/convBlockFsm.sv */
`timescale 1ns/10ps

module convBlockFsm #(
    parameter int MAX_LENGTH = 2 ** convImgPkg::ADDR_W
) (
    input  logic                          i_CLK,
    input  logic                          i_reset,
    input  logic [convImgPkg::ADDR_W-1:0] i_imgLength,
    input  logic                          i_load,
    input  logic                          i_SoP,
    input  logic                          i_valid,
    output convCtrlPkg::wrCmd_t           o_pixWr,
    output convCtrlPkg::rdCmd_t           o_pixRd,
    output convCtrlPkg::wrCmd_t           o_resWr,
    output convCtrlPkg::rdCmd_t           o_resRd,
    output logic                          o_EoP,
    output logic                          o_changeBlock,
    output logic                          o_processing
);

    // spare bit lets the counters run past the last address
    localparam int CNT_W = convImgPkg::ADDR_W + 1;
    localparam int WR_START = 2 + convImgPkg::PIPE_LATENCY;

    convCtrlPkg::phase_t phase;

    logic [CNT_W-1:0] imgLen;
    logic [CNT_W-1:0] rdCnt;
    logic [CNT_W-1:0] wrCnt;
    logic [CNT_W-1:0] xferTarget;
    logic             eopFlag;
    logic             validPrev;
    logic             validEdge;
    logic             xferIdle;

    assign validEdge = i_valid & ~validPrev;

    // readout returns two results fewer than the pixels loaded
    assign xferTarget = eopFlag ? imgLen - CNT_W'(2) : imgLen;

    // last transfer strobe already presented
    assign xferIdle = ~o_pixWr.wrEn & ~o_resRd.rdEn;

    assign o_EoP = eopFlag;
    assign o_processing = (phase == convCtrlPkg::PROCESS);

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            validPrev <= 1'b0;
        end else begin
            validPrev <= i_valid;
        end
    end

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            phase         <= convCtrlPkg::IDLE;
            imgLen        <= '0;
            rdCnt         <= '0;
            wrCnt         <= '0;
            eopFlag       <= 1'b0;
            o_changeBlock <= 1'b0;
            o_pixWr       <= '0;
            o_pixRd       <= '0;
            o_resWr       <= '0;
            o_resRd       <= '0;
        end else begin
            // strobes last a single cycle
            o_pixWr.wrEn  <= 1'b0;
            o_pixRd.rdEn  <= 1'b0;
            o_resWr.wrEn  <= 1'b0;
            o_resRd.rdEn  <= 1'b0;
            o_changeBlock <= 1'b0;

            case (phase)
                convCtrlPkg::IDLE: begin
                    rdCnt <= '0;
                    wrCnt <= '0;
                    if (i_load && !i_SoP && !eopFlag) begin
                        // new row, length clamped to buffer depth
                        if (i_imgLength > MAX_LENGTH) begin
                            imgLen <= CNT_W'(MAX_LENGTH);
                        end else begin
                            imgLen <= CNT_W'(i_imgLength);
                        end
                        phase <= convCtrlPkg::XFER;
                    end else if (!i_load && i_SoP && !eopFlag) begin
                        phase <= convCtrlPkg::PROCESS;
                    end else if (!i_load && !i_SoP && eopFlag) begin
                        phase <= convCtrlPkg::XFER;
                    end
                end

                convCtrlPkg::XFER: begin
                    if (eopFlag && i_load) begin
                        // readout abort
                        eopFlag       <= 1'b0;
                        o_changeBlock <= 1'b1;
                        phase         <= convCtrlPkg::IDLE;
                    end else if (rdCnt == xferTarget) begin
                        // block done once its last strobe has gone out
                        if (xferIdle) begin
                            eopFlag       <= 1'b0;
                            o_changeBlock <= 1'b1;
                            phase         <= convCtrlPkg::IDLE;
                        end
                    end else if (validEdge) begin
                        if (eopFlag) begin
                            o_resRd <= '{
                                rdEn:   1'b1,
                                rdAddr: rdCnt[convImgPkg::ADDR_W-1:0]
                            };
                        end else begin
                            o_pixWr <= '{
                                wrEn:   1'b1,
                                wrAddr: rdCnt[convImgPkg::ADDR_W-1:0]
                            };
                        end
                        rdCnt <= rdCnt + CNT_W'(1);
                    end
                end

                convCtrlPkg::PROCESS: begin
                    // rdCnt keeps counting cycles after the last read
                    rdCnt <= rdCnt + CNT_W'(1);
                    if (rdCnt < imgLen) begin
                        o_pixRd <= '{
                            rdEn:   1'b1,
                            rdAddr: rdCnt[convImgPkg::ADDR_W-1:0]
                        };
                    end
                    // result j appears PIPE_LATENCY cycles after read j+2
                    if (rdCnt >= CNT_W'(WR_START)) begin
                        o_resWr <= '{
                            wrEn:   1'b1,
                            wrAddr: wrCnt[convImgPkg::ADDR_W-1:0]
                        };
                        wrCnt <= wrCnt + CNT_W'(1);
                        // EoP rises with the last result write
                        if (wrCnt == imgLen - CNT_W'(3)) begin
                            eopFlag <= 1'b1;
                            phase   <= convCtrlPkg::DONE;
                        end
                    end
                end

                convCtrlPkg::DONE: begin
                    if (!i_SoP) begin
                        phase <= convCtrlPkg::IDLE;
                    end
                end

                default: begin
                    phase <= convCtrlPkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* source/rowBuffer.sv */
`timescale 1ns/10ps

module rowBuffer #(
    parameter int WIDTH      = 8,
    parameter int MAX_LENGTH = 2 ** convImgPkg::ADDR_W
) (
    input  logic                i_CLK,
    input  logic                i_reset,
    input  convCtrlPkg::wrCmd_t i_wr,
    input  logic [WIDTH-1:0]    i_wrData,
    input  convCtrlPkg::rdCmd_t i_rd,
    output logic [WIDTH-1:0]    o_rdData,
    output logic                o_rdVld
);

    logic [WIDTH-1:0] mem [MAX_LENGTH];

    // single clock, write and registered read
    always_ff @(posedge i_CLK) begin
        if (i_wr.wrEn) begin
            mem[i_wr.wrAddr] <= i_wrData;
        end
        if (i_rd.rdEn) begin
            o_rdData <= mem[i_rd.rdAddr];
        end
    end

    // valid follows the read strobe by one cycle
    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            o_rdVld <= 1'b0;
        end else begin
            o_rdVld <= i_rd.rdEn;
        end
    end

endmodule

/* source/convPipeline.sv */
`timescale 1ns/10ps

module convPipeline #(
    parameter convImgPkg::kernel_t KERNEL = convImgPkg::DEFAULT_KERNEL
) (
    input  logic                i_CLK,
    input  logic                i_reset,
    input  convImgPkg::pixel_t  i_pixel,
    output convImgPkg::result_t o_result
);

    // signed coef times zero-extended pixel
    localparam int PROD_W = $bits(convImgPkg::coef_t) + $bits(convImgPkg::pixel_t) + 1;
    localparam int SUM_W  = PROD_W + 1;

    // window[2] is the newest pixel, window[0] the oldest
    convImgPkg::pixel_t [2:0] window;

    logic signed [PROD_W-1:0] prod0;
    logic signed [PROD_W-1:0] prod1;
    logic signed [PROD_W-1:0] prod2;
    logic signed [PROD_W-1:0] prod2Dly;
    logic signed [SUM_W-1:0]  sum01;

    always_ff @(posedge i_CLK) begin
        if (i_reset) begin
            window   <= '0;
            prod0    <= '0;
            prod1    <= '0;
            prod2    <= '0;
            prod2Dly <= '0;
            sum01    <= '0;
            o_result <= '0;
        end else begin
            // stage 1 shift in
            window <= {i_pixel, window[2:1]};

            // stage 2 multiply
            prod0 <= $signed(KERNEL.tap0) * $signed({1'b0, window[0]});
            prod1 <= $signed(KERNEL.tap1) * $signed({1'b0, window[1]});
            prod2 <= $signed(KERNEL.tap2) * $signed({1'b0, window[2]});

            // stages 3 and 4 adder tree
            sum01    <= prod0 + prod1;
            prod2Dly <= prod2;
            o_result <= sum01 + prod2Dly;
        end
    end

endmodule

/* source/convBlockTop.sv */
`timescale 1ns/10ps

module convBlockTop #(
    parameter int                  MAX_LENGTH = 2 ** convImgPkg::ADDR_W,
    parameter convImgPkg::kernel_t KERNEL     = convImgPkg::DEFAULT_KERNEL
) (
    input  logic                          i_CLK,
    input  logic                          i_reset,
    input  logic [convImgPkg::ADDR_W-1:0] i_imgLength,
    input  logic                          i_load,
    input  logic                          i_SoP,
    input  logic                          i_valid,
    input  convImgPkg::pixel_t            i_pixel,
    output convImgPkg::result_t           o_result,
    output logic                          o_resultVld,
    output logic                          o_EoP,
    output logic                          o_changeBlock,
    output logic                          o_processing
);

    convCtrlPkg::wrCmd_t pixWr;
    convCtrlPkg::rdCmd_t pixRd;
    convCtrlPkg::wrCmd_t resWr;
    convCtrlPkg::rdCmd_t resRd;
    convImgPkg::pixel_t  pixRdData;
    convImgPkg::result_t convOut;

    convBlockFsm #(
        .MAX_LENGTH(MAX_LENGTH)
    ) u_fsm (
        .i_CLK        (i_CLK),
        .i_reset      (i_reset),
        .i_imgLength  (i_imgLength),
        .i_load       (i_load),
        .i_SoP        (i_SoP),
        .i_valid      (i_valid),
        .o_pixWr      (pixWr),
        .o_pixRd      (pixRd),
        .o_resWr      (resWr),
        .o_resRd      (resRd),
        .o_EoP        (o_EoP),
        .o_changeBlock(o_changeBlock),
        .o_processing (o_processing)
    );

    // pixel is written the cycle after the i_valid edge,
    // so i_pixel must still hold it then
    rowBuffer #(
        .WIDTH     ($bits(convImgPkg::pixel_t)),
        .MAX_LENGTH(MAX_LENGTH)
    ) u_pixBuf (
        .i_CLK   (i_CLK),
        .i_reset (i_reset),
        .i_wr    (pixWr),
        .i_wrData(i_pixel),
        .i_rd    (pixRd),
        .o_rdData(pixRdData),
        .o_rdVld ()
    );

    convPipeline #(
        .KERNEL(KERNEL)
    ) u_conv (
        .i_CLK   (i_CLK),
        .i_reset (i_reset),
        .i_pixel (pixRdData),
        .o_result(convOut)
    );

    rowBuffer #(
        .WIDTH     ($bits(convImgPkg::result_t)),
        .MAX_LENGTH(MAX_LENGTH)
    ) u_resBuf (
        .i_CLK   (i_CLK),
        .i_reset (i_reset),
        .i_wr    (resWr),
        .i_wrData(convOut),
        .i_rd    (resRd),
        .o_rdData(o_result),
        .o_rdVld (o_resultVld)
    );

endmodule

/* test/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic o_CLK,
    output logic o_reset
);

    initial begin
        o_CLK = 1'b0;
        forever begin
            #(PERIOD_NS / 2) o_CLK = ~o_CLK;
        end
    end

    // released on a falling edge
    initial begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_CLK);
        @(negedge o_CLK);
        o_reset = 1'b0;
    end

endmodule

/* test/convBlockTb.sv */
`timescale 1ns/10ps

module convBlockTb;

    localparam int CLK_PERIOD   = 100;
    localparam int MAX_LENGTH   = 1024;
    localparam int MAX_TEST_LEN = 64;
    localparam int NUM_ROWS     = 6;
    // main rows plus the aborted row and the row after it
    localparam int TOTAL_ROWS   = NUM_ROWS + 2;
    localparam longint WATCHDOG_NS = longint'(TOTAL_ROWS + 1) * longint'(3 * MAX_LENGTH + 40)
                                     * longint'(CLK_PERIOD);
    // buffer read, window shift, multiply, two adder stages
    localparam int LATENCY = 1 + 1 + 1 + 2;
    localparam int TAP0 = 1;
    localparam int TAP1 = -2;
    localparam int TAP2 = 3;
    localparam logic [31:0] SEED = 32'h8e2d4162;

    logic                clk;
    logic                rst;
    logic [9:0]          imgLength;
    logic                load;
    logic                sop;
    logic                valid;
    convImgPkg::pixel_t  pixel;
    convImgPkg::result_t result;
    logic                resultVld;
    logic                eop;
    logic                changeBlock;
    logic                processing;

    logic [7:0]  modelRow [MAX_TEST_LEN];
    logic [19:0] gotResults [$];
    int          cbCount;

    clockGen #(
        .PERIOD_NS   (CLK_PERIOD),
        .RESET_CYCLES(8)
    ) u_clkGen (
        .o_CLK  (clk),
        .o_reset(rst)
    );

    convBlockTop DUT (
        .i_CLK        (clk),
        .i_reset      (rst),
        .i_imgLength  (imgLength),
        .i_load       (load),
        .i_SoP        (sop),
        .i_valid      (valid),
        .i_pixel      (pixel),
        .o_result     (result),
        .o_resultVld  (resultVld),
        .o_EoP        (eop),
        .o_changeBlock(changeBlock),
        .o_processing (processing)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            failRun($sformatf("ERR %s expected 0x%0h got 0x%0h", name, exp, got));
        end
    endtask

    // outputs sampled on the falling edge before the next inputs are driven
    task automatic stepCycle();
        @(negedge clk);
        if (changeBlock) begin
            cbCount++;
        end
        if (resultVld) begin
            gotResults.push_back(result);
        end
    endtask

    task automatic pulseValid();
        int hold;
        int gap;
        hold = int'($urandom_range(4, 1));
        gap = int'($urandom_range(3, 1));
        valid = 1'b1;
        repeat (hold) stepCycle();
        valid = 1'b0;
        repeat (gap) stepCycle();
    endtask

    task automatic waitChangeBlock(input int target, input string what);
        int waited;
        waited = 0;
        while (cbCount < target && waited < 20) begin
            stepCycle();
            waited++;
        end
        assert (cbCount >= target) else begin
            failRun({"o_changeBlock did not pulse at the end of the ", what});
        end
    endtask

    // tap rule of the kernel
    function automatic logic [19:0] modelResult(input int j);
        int sum;
        sum = TAP0 * int'(modelRow[j]) + TAP1 * int'(modelRow[j + 1])
              + TAP2 * int'(modelRow[j + 2]);
        return 20'(sum);
    endfunction

    task automatic loadRow(input int len);
        int cbStart;
        int i;
        cbStart = cbCount;
        imgLength = 10'(len);
        load = 1'b1;
        // controller enters the load phase on this edge
        stepCycle();
        for (i = 0; i < len; i++) begin
            expectEqual("o_changeBlock pulses during load", 32'(cbCount - cbStart), 32'd0);
            modelRow[i] = 8'($urandom_range(255, 0));
            pixel = modelRow[i];
            if (i == len - 1) begin
                load = 1'b0;
            end
            pulseValid();
        end
        waitChangeBlock(cbStart + 1, "load");
        repeat (3) stepCycle();
        expectEqual("o_changeBlock pulses after load", 32'(cbCount - cbStart), 32'd1);
    endtask

    task automatic processRow(input int len);
        int waited;
        int cycles;
        int expCycles;
        int holdSop;
        // last result comes LATENCY cycles after read L-1
        expCycles = (len - 1) + LATENCY;
        sop = 1'b1;
        waited = 0;
        stepCycle();
        while (!processing && waited < 5) begin
            stepCycle();
            waited++;
        end
        assert (processing) else begin
            failRun("o_processing did not rise after i_SoP");
        end
        expectEqual("o_processing delay", 32'(waited), 32'd0);
        // first pixel read
        stepCycle();
        cycles = 0;
        while (!eop && cycles < expCycles + 20) begin
            stepCycle();
            cycles++;
        end
        assert (eop) else begin
            failRun("o_EoP did not rise during processing");
        end
        expectEqual("o_EoP rise cycle", 32'(cycles), 32'(expCycles));
        holdSop = int'($urandom_range(5, 1));
        repeat (holdSop) begin
            stepCycle();
            expectEqual("o_EoP", 32'(eop), 32'd1);
            expectEqual("o_processing", 32'(processing), 32'd0);
        end
        sop = 1'b0;
        // done to idle and then idle into readout
        repeat (2) stepCycle();
    endtask

    task automatic readoutRow(input int len, input int abortAt);
        int cbStart;
        int count;
        int i;
        cbStart = cbCount;
        gotResults.delete();
        count = (abortAt > 0) ? abortAt : len - 2;
        for (i = 0; i < count; i++) begin
            expectEqual("o_changeBlock pulses during readout", 32'(cbCount - cbStart), 32'd0);
            pulseValid();
        end
        if (abortAt > 0) begin
            load = 1'b1;
            stepCycle();
            expectEqual("o_changeBlock on abort", 32'(changeBlock), 32'd1);
            // dropped before idle could start a new load
            load = 1'b0;
        end else begin
            waitChangeBlock(cbStart + 1, "readout");
        end
        repeat (3) stepCycle();
        expectEqual("o_changeBlock pulses after readout", 32'(cbCount - cbStart), 32'd1);
        expectEqual("o_EoP", 32'(eop), 32'd0);
        expectEqual("o_result count", 32'(gotResults.size()), 32'(count));
        for (i = 0; i < count; i++) begin
            expectEqual($sformatf("o_result[%0d]", i), 32'(gotResults[i]),
                        32'(modelResult(i)));
        end
    endtask

    task automatic runRow(input int len);
        loadRow(len);
        processRow(len);
        readoutRow(len, 0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        failRun("watchdog timeout: the run did not finish in its time limit");
    end

    initial begin
        int len;
        int row;
        int abortAt;
        imgLength = '0;
        load = 1'b0;
        sop = 1'b0;
        valid = 1'b0;
        pixel = '0;
        cbCount = 0;
        void'($urandom(SEED));
        wait (rst === 1'b1);
        wait (rst === 1'b0);
        stepCycle();
        expectEqual("o_EoP after reset", 32'(eop), 32'd0);
        expectEqual("o_changeBlock after reset", 32'(changeBlock), 32'd0);
        expectEqual("o_resultVld after reset", 32'(resultVld), 32'd0);
        expectEqual("o_processing after reset", 32'(processing), 32'd0);
        for (row = 0; row < NUM_ROWS; row++) begin
            // shortest legal row first
            len = (row == 0) ? 3 : int'($urandom_range(MAX_TEST_LEN, 3));
            runRow(len);
        end
        // readout cut short by i_load and a fresh row after it
        len = int'($urandom_range(MAX_TEST_LEN, 10));
        abortAt = int'($urandom_range(len - 3, 1));
        loadRow(len);
        processRow(len);
        readoutRow(len, abortAt);
        len = int'($urandom_range(MAX_TEST_LEN, 3));
        runRow(len);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* compile.f */
source/convImgPkg.sv
source/convCtrlPkg.sv
source/convBlockFsm.sv
source/rowBuffer.sv
source/convPipeline.sv
source/convBlockTop.sv
test/clockGen.sv
test/convBlockTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module convBlockTb \
    --Mdir "$BUILD_DIR" \
    -o convBlockSim

# a failing run still leaves its log for the search below
"$BUILD_DIR/convBlockSim" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    exit 1
fi
exit 0
